//--- logic/bus_pkg.sv
package bus_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int BUS_DW = 32;
	localparam int BUS_AW = 32;
	// Word address handed on to the external RAM controller
	localparam int EXT_AW = 26;
	// Block RAM depth of 1024 words
	localparam int BLK_AW = 10;
	localparam int IO_AW = 3;
	localparam int LED_W = 4;
	localparam int SW_W = 4;

	typedef logic [BUS_DW-1:0] bus_word_t;
	typedef logic [BUS_AW-1:0] bus_addr_t;

	// One region per slave, plus nothing selected
	typedef enum logic [1:0]
	{
		REGION_NONE = 2'd0,
		REGION_IO   = 2'd1,
		REGION_BLK  = 2'd2,
		REGION_EXT  = 2'd3
	} region_e;

	// I/O register indices, the rest read as zero
	localparam logic [IO_AW-1:0] IO_ERR_ADDR = 3'd0;
	localparam logic [IO_AW-1:0] IO_SWITCHES = 3'd1;
	localparam logic [IO_AW-1:0] IO_LEDS     = 3'd2;

	////////////////////
	// Address map
	////////////////////
	// Skip bits, highest one set picks the region
	localparam int EXT_SEL_BIT = 26;
	localparam int BLK_SEL_BIT = 15;
	localparam int IO_SEL_BIT  = 8;
	// Any of bits 31..27 set is off the map
	localparam bus_addr_t UNMAPPED_MASK = 32'hF800_0000;
	// Bits that must be clear in a block RAM address
	localparam bus_addr_t BLK_ZERO_MASK = 32'h03FF_7C00;
	// Bits that must be clear in an I/O address
	localparam bus_addr_t IO_ZERO_MASK  = 32'h03FF_7EF8;

endpackage

//--- logic/bus_decode.sv
`timescale 1ns/1ps

module bus_decode
(
	input  bus_pkg::bus_addr_t i_addr,
	output bus_pkg::region_e   o_region
);
	import bus_pkg::*;

	logic off_map;
	logic ext_hit;
	logic blk_hit;
	logic io_hit;
	logic blk_clean;
	logic io_clean;

	////////////////////
	// Skip bit priority
	////////////////////
	// Top five bits reserved
	assign off_map = |(i_addr & UNMAPPED_MASK);

	// External RAM owns everything with bit 26 set
	assign ext_hit = i_addr[EXT_SEL_BIT];

	// Block RAM below external, I/O below block RAM
	assign blk_hit = !i_addr[EXT_SEL_BIT] && i_addr[BLK_SEL_BIT];
	assign io_hit  = !i_addr[EXT_SEL_BIT] && !i_addr[BLK_SEL_BIT]
		&& i_addr[IO_SEL_BIT];

	// Unused bits inside a region must be zero
	assign blk_clean = ~|(i_addr & BLK_ZERO_MASK);
	assign io_clean  = ~|(i_addr & IO_ZERO_MASK);

	////////////////////
	// Region select
	////////////////////
	always_comb
	begin
		// Malformed and unmapped both end up here
		o_region = REGION_NONE;
		if (off_map)
		begin
			o_region = REGION_NONE;
		end
		else if (ext_hit)
		begin
			o_region = REGION_EXT;
		end
		else if (blk_hit && blk_clean)
		begin
			o_region = REGION_BLK;
		end
		else if (io_hit && io_clean)
		begin
			o_region = REGION_IO;
		end
	end

endmodule

//--- logic/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl
(
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  logic               i_wb_cyc,
	input  logic               i_wb_stb,
	input  bus_pkg::bus_addr_t i_wb_addr,
	input  bus_pkg::region_e   i_region,
	input  logic               i_ram_stall,
	input  logic               i_ram_ack,
	input  logic               i_ram_err,
	input  logic               i_blk_ack,
	input  logic               i_io_ack,
	output logic               o_wb_stall,
	output logic               o_wb_ack,
	output logic               o_wb_err,
	output logic               o_blk_stb,
	output logic               o_io_stb,
	output logic               o_ram_stb,
	output logic               o_bus_err,
	output bus_pkg::bus_addr_t o_last_addr
);
	import bus_pkg::*;

	logic req;
	logic accept;
	logic any_ack;
	logic multi_ack;
	logic err_next;

	////////////////////
	// Strobe routing
	////////////////////
	assign req = i_wb_cyc && i_wb_stb;

	// Only the external RAM ever holds the master off
	assign o_wb_stall = i_wb_cyc && (i_region == REGION_EXT) && i_ram_stall;
	assign accept     = req && !o_wb_stall;

	assign o_blk_stb = req && (i_region == REGION_BLK);
	assign o_io_stb  = req && (i_region == REGION_IO);
	// Held high through a stall, the RAM sees its own stall
	assign o_ram_stb = req && (i_region == REGION_EXT);

	////////////////////
	// Ack and error
	////////////////////
	assign any_ack   = i_blk_ack || i_io_ack || i_ram_ack;
	// Two or more slaves answering at once
	assign multi_ack = (i_blk_ack && i_io_ack) || (i_blk_ack && i_ram_ack)
		|| (i_io_ack && i_ram_ack);

	assign err_next = i_wb_cyc && ((accept && (i_region == REGION_NONE))
		|| multi_ack || i_ram_err);

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_wb_ack <= 1'b0;
			o_wb_err <= 1'b0;
		end
		else
		begin
			// An error replaces the ack of the same cycle
			o_wb_ack <= i_wb_cyc && any_ack && !err_next;
			o_wb_err <= err_next;
		end
	end

	// Same pulse drives the error address capture
	assign o_bus_err = o_wb_err;

	// Address of the newest accepted strobe
	always_ff @(posedge i_clk)
	begin
		if (accept)
			o_last_addr <= i_wb_addr;
	end

	// On-chip slaves only answer a strobe of the cycle before
	a_blk_ack_strobed: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_blk_ack |-> $past(o_blk_stb));
	a_io_ack_strobed: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_io_ack |-> $past(o_io_stb));

endmodule

//--- logic/resp_mux.sv
`timescale 1ns/1ps

module resp_mux
(
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  logic               i_blk_ack,
	input  logic               i_io_ack,
	input  logic               i_ram_ack,
	input  bus_pkg::bus_word_t i_blk_data,
	input  bus_pkg::bus_word_t i_io_data,
	input  bus_pkg::bus_word_t i_ram_data,
	output bus_pkg::bus_word_t o_data
);

	////////////////////
	// Return word
	////////////////////
	// Lines up with the registered ack in the control block
	always_ff @(posedge i_clk)
	begin
		if (i_ram_ack)
			o_data <= i_ram_data;
		else if (i_blk_ack)
			o_data <= i_blk_data;
		else if (i_io_ack)
			o_data <= i_io_data;
		// Otherwise hold the last word
	end

	// Both on-chip slaves answer one cycle after their strobe,
	// so they can never overlap
	a_onchip_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_blk_ack && i_io_ack));

endmodule

//--- logic/blk_ram.sv
`timescale 1ns/1ps

module blk_ram
#(
	parameter int AW = bus_pkg::BLK_AW
)
(
	input  logic               i_clk,
	input  logic               i_stb,
	input  logic               i_we,
	input  logic [AW-1:0]      i_addr,
	input  bus_pkg::bus_word_t i_data,
	output logic               o_ack,
	output bus_pkg::bus_word_t o_data
);
	import bus_pkg::*;

	// Word array, maps onto block RAM
	bus_word_t mem [0:(1<<AW)-1];

	////////////////////
	// Write port
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_we)
			mem[i_addr] <= i_data;
	end

	////////////////////
	// Read port
	////////////////////
	// Old contents on a write strobe
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
			o_data <= mem[i_addr];
	end

	// Every strobe answers next cycle, never stalls
	always_ff @(posedge i_clk)
	begin
		o_ack <= i_stb;
	end

endmodule

//--- logic/io_regs.sv
`timescale 1ns/1ps

module io_regs
(
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic                      i_stb,
	input  logic                      i_we,
	input  logic [bus_pkg::IO_AW-1:0] i_idx,
	input  bus_pkg::bus_word_t        i_data,
	input  logic [bus_pkg::SW_W-1:0]  i_sw,
	input  logic                      i_bus_err,
	input  bus_pkg::bus_addr_t        i_err_addr,
	output logic                      o_ack,
	output bus_pkg::bus_word_t        o_data,
	output logic [bus_pkg::LED_W-1:0] o_led
);
	import bus_pkg::*;

	bus_addr_t       err_addr;
	logic [SW_W-1:0] sw_meta;
	logic [SW_W-1:0] sw_sync;

	////////////////////
	// Control registers
	////////////////////
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			err_addr <= '0;
			sw_meta  <= '0;
			sw_sync  <= '0;
			o_led    <= '0;
			o_ack    <= 1'b0;
		end
		else
		begin
			// Address behind the latest bus error
			if (i_bus_err)
				err_addr <= i_err_addr;
			// Switches are asynchronous to the bus clock
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
			if (i_stb && i_we && (i_idx == IO_LEDS))
				o_led <= i_data[LED_W-1:0];
			o_ack <= i_stb;
		end
	end

	////////////////////
	// Read data
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			case (i_idx)
			IO_ERR_ADDR: o_data <= err_addr;
			IO_SWITCHES: o_data <= bus_word_t'(sw_sync);
			IO_LEDS:     o_data <= bus_word_t'(o_led);
			default:     o_data <= '0;
			endcase
		end
	end

endmodule

//--- logic/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric
(
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	// Master side
	input  logic                       i_wb_cyc,
	input  logic                       i_wb_stb,
	input  logic                       i_wb_we,
	input  bus_pkg::bus_addr_t         i_wb_addr,
	input  bus_pkg::bus_word_t         i_wb_data,
	output logic                       o_wb_stall,
	output logic                       o_wb_ack,
	output bus_pkg::bus_word_t         o_wb_data,
	output logic                       o_wb_err,
	// External RAM controller
	output logic                       o_ram_stb,
	output logic                       o_ram_we,
	output logic [bus_pkg::EXT_AW-1:0] o_ram_addr,
	output bus_pkg::bus_word_t         o_ram_wdata,
	input  logic                       i_ram_ack,
	input  logic                       i_ram_stall,
	input  bus_pkg::bus_word_t         i_ram_rdata,
	input  logic                       i_ram_err,
	// Board I/O
	input  logic [bus_pkg::SW_W-1:0]   i_sw,
	output logic [bus_pkg::LED_W-1:0]  o_led
);
	import bus_pkg::*;

	region_e   region;
	logic      blk_stb;
	logic      io_stb;
	logic      blk_ack;
	logic      io_ack;
	bus_word_t blk_data;
	bus_word_t io_data;
	logic      bus_err;
	bus_addr_t last_addr;

	////////////////////
	// Decode and control
	////////////////////
	bus_decode u_decode (
		.i_addr(i_wb_addr), .o_region(region)
	);

	bus_ctrl u_ctrl (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_addr(i_wb_addr),
		.i_region(region),
		.i_ram_stall(i_ram_stall), .i_ram_ack(i_ram_ack), .i_ram_err(i_ram_err),
		.i_blk_ack(blk_ack), .i_io_ack(io_ack),
		.o_wb_stall(o_wb_stall), .o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err),
		.o_blk_stb(blk_stb), .o_io_stb(io_stb), .o_ram_stb(o_ram_stb),
		.o_bus_err(bus_err), .o_last_addr(last_addr)
	);

	resp_mux u_mux (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_blk_ack(blk_ack), .i_io_ack(io_ack), .i_ram_ack(i_ram_ack),
		.i_blk_data(blk_data), .i_io_data(io_data), .i_ram_data(i_ram_rdata),
		.o_data(o_wb_data)
	);

	////////////////////
	// Slaves
	////////////////////
	blk_ram #(.AW(BLK_AW)) u_blk (
		.i_clk(i_clk), .i_stb(blk_stb), .i_we(i_wb_we),
		.i_addr(i_wb_addr[BLK_AW-1:0]), .i_data(i_wb_data),
		.o_ack(blk_ack), .o_data(blk_data)
	);

	io_regs u_io (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_stb(io_stb), .i_we(i_wb_we),
		.i_idx(i_wb_addr[IO_AW-1:0]), .i_data(i_wb_data), .i_sw(i_sw),
		.i_bus_err(bus_err), .i_err_addr(last_addr),
		.o_ack(io_ack), .o_data(io_data), .o_led(o_led)
	);

	// External RAM sees the master request directly
	assign o_ram_we    = i_wb_we;
	assign o_ram_addr  = i_wb_addr[EXT_AW-1:0];
	assign o_ram_wdata = i_wb_data;

endmodule

//--- test/tb_bus_fabric.sv
`timescale 1ns/1ps

module tb_bus_fabric;
	import bus_pkg::*;

	// Whole run is about 750 cycles at 3 cycles per on-chip access,
	// so the limit is roughly four times that
	localparam int MAX_CYCLES = 3000;
	// Cycles to wait for ack or error after accept
	localparam int RESP_WAIT = 16;

	logic              clk = 1'b0;
	logic              arst_n;
	logic              cyc;
	logic              stb;
	logic              we;
	bus_addr_t         addr;
	bus_word_t         wdata;
	logic              stall;
	logic              ack;
	bus_word_t         rdata;
	logic              err;
	logic              ram_stb;
	logic              ram_we;
	logic [EXT_AW-1:0] ram_addr;
	bus_word_t         ram_wdata;
	logic              ram_ack;
	logic              spur_ack;
	logic              ram_stall;
	bus_word_t         ram_rdata;
	logic              ram_err;
	logic              err_inject;
	logic [SW_W-1:0]   sw;
	logic [LED_W-1:0]  led;

	// Expected responses, oldest first
	logic      exp_err_q[$];
	logic      exp_chk_q[$];
	bus_word_t exp_data_q[$];
	logic      want_err;
	logic      want_chk;
	bus_word_t want_data;

	bus_word_t shadow [0:(1<<BLK_AW)-1];
	bus_word_t rng_state = 32'd8631;
	int        checks = 0;
	int        errors = 0;
	int        err_mark = 0;
	int        test_num = 0;

	always #5 clk = ~clk;

	bus_fabric UUT (
		.i_clk(clk), .i_arst_n(arst_n),
		.i_wb_cyc(cyc), .i_wb_stb(stb), .i_wb_we(we), .i_wb_addr(addr), .i_wb_data(wdata),
		.o_wb_stall(stall), .o_wb_ack(ack), .o_wb_data(rdata), .o_wb_err(err),
		.o_ram_stb(ram_stb), .o_ram_we(ram_we), .o_ram_addr(ram_addr),
		.o_ram_wdata(ram_wdata), .i_ram_ack(ram_ack | spur_ack), .i_ram_stall(ram_stall),
		.i_ram_rdata(ram_rdata), .i_ram_err(ram_err),
		.i_sw(sw), .o_led(led)
	);

	////////////////////
	// Reference model
	////////////////////
	function automatic bus_word_t next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Region straight from the address map
	function automatic region_e ref_region(input bus_addr_t a);
		if (|a[31:27])
			return REGION_NONE;
		if (a[26])
			return REGION_EXT;
		if (a[15])
			return (~|a[25:16] && ~|a[14:10]) ? REGION_BLK : REGION_NONE;
		if (a[8])
			return (~|a[25:16] && ~|a[14:9] && ~|a[7:3]) ? REGION_IO : REGION_NONE;
		return REGION_NONE;
	endfunction

	// External RAM contents, a fixed scramble of its address
	function automatic bus_word_t ram_word(input logic [EXT_AW-1:0] a);
		return {a, 6'h15} ^ 32'hC3A5_0F1E;
	endfunction

	function automatic bus_addr_t blk_addr(input logic [BLK_AW-1:0] idx);
		return {16'd0, 1'b1, 5'd0, idx};
	endfunction

	function automatic bus_addr_t io_addr(input logic [IO_AW-1:0] idx);
		return {29'd32, idx};
	endfunction

	////////////////////
	// Checks
	////////////////////
	task automatic compare_word(input bus_word_t got, input bus_word_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic match_addr(input bus_addr_t got, input bus_addr_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic verify_region(input region_e got, input region_e exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic flag_check(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		test_num++;
		$display("Test %0d %s finished with %0d errors", test_num, name, errors - err_mark);
		err_mark = errors;
	endtask

	// One master access, waits for its ack or error
	task automatic bus_access(input logic w, input bus_addr_t a, input bus_word_t d,
		input logic exp_err, input logic exp_chk, input bus_word_t exp_data, input logic spur);
		int waited;
		@(negedge clk);
		exp_err_q.push_back(exp_err);
		exp_chk_q.push_back(exp_chk);
		exp_data_q.push_back(exp_data);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = w;
		addr  = a;
		wdata = d;
		// Request held unchanged while stalled
		do
		begin
			@(posedge clk);
			flag_check(stall, (ref_region(a) == REGION_EXT) && ram_stall, "stall");
		end
		while (stall);
		verify_region(UUT.region, ref_region(a), "decoded region");
		@(negedge clk);
		stb = 1'b0;
		waited = 0;
		while (!(ack || err) && (waited < RESP_WAIT))
		begin
			// Extra ack lines up with the block RAM ack
			spur_ack = spur && (waited == 0);
			@(negedge clk);
			waited++;
		end
		spur_ack = 1'b0;
		cyc = 1'b0;
		if (!(ack || err))
		begin
			errors++;
			$display("No ack or error within %0d cycles for address %h", RESP_WAIT, a);
			exp_err_q.delete();
			exp_chk_q.delete();
			exp_data_q.delete();
		end
	endtask

	////////////////////
	// Response checker
	////////////////////
	initial
	begin : compare_responses
		forever
		begin
			@(negedge clk);
			if (arst_n && (ack || err))
			begin
				if (exp_err_q.size() == 0)
				begin
					errors++;
					$display("Response at %0t ns with no access outstanding", $time);
				end
				else
				begin
					want_err  = exp_err_q.pop_front();
					want_chk  = exp_chk_q.pop_front();
					want_data = exp_data_q.pop_front();
					flag_check(err, want_err, "bus error");
					flag_check(ack, !want_err, "bus ack");
					if (want_chk)
						compare_word(rdata, want_data, "read data");
				end
			end
		end
	end

	////////////////////
	// External RAM model
	////////////////////
	initial
	begin : ram_responder
		bus_word_t         r;
		int                delay;
		int                stall_left;
		logic [EXT_AW-1:0] seen_addr;
		ram_ack    = 1'b0;
		ram_err    = 1'b0;
		ram_stall  = 1'b0;
		ram_rdata  = '0;
		stall_left = 0;
		forever
		begin
			@(posedge clk);
			if (ram_stb && ram_stall)
			begin
				@(negedge clk);
				stall_left--;
				ram_stall = (stall_left > 0);
			end
			else if (ram_stb)
			begin
				// Accepted, master fields come through untouched
				flag_check(ram_we, we, "forwarded write enable");
				match_addr({6'd0, ram_addr}, {6'd0, addr[EXT_AW-1:0]}, "forwarded address");
				if (we)
					compare_word(ram_wdata, wdata, "forwarded write data");
				seen_addr = ram_addr;
				r = next_rand();
				delay = 1 + int'(r % 3);
				repeat (delay - 1) @(posedge clk);
				@(negedge clk);
				ram_ack   = 1'b1;
				ram_err   = err_inject;
				ram_rdata = ram_word(seen_addr);
				@(negedge clk);
				ram_ack = 1'b0;
				ram_err = 1'b0;
				// Stall for the next request
				r = next_rand();
				stall_left = int'(r % 4);
				ram_stall = (stall_left > 0);
			end
		end
	end

	initial
	begin : cycle_limit
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Verification failed");
		$finish;
	end

	////////////////////
	// Stimulus
	////////////////////
	initial
	begin : stimulus
		bus_word_t         r;
		bus_addr_t         a;
		logic [BLK_AW-1:0] blk_idx [64];
		int                i;
		arst_n     = 1'b0;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		addr       = '0;
		wdata      = '0;
		sw         = '0;
		spur_ack   = 1'b0;
		err_inject = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		// Outputs idle out of reset
		flag_check(ack, 1'b0, "ack in reset");
		flag_check(err, 1'b0, "error in reset");
		flag_check(ram_stb, 1'b0, "RAM strobe in reset");
		compare_word({28'd0, led}, '0, "LEDs in reset");
		arst_n = 1'b1;

		// Random writes then reads against the shadow
		for (i = 0; i < 64; i++)
		begin
			r = next_rand();
			blk_idx[i] = r[BLK_AW-1:0];
			r = next_rand();
			shadow[blk_idx[i]] = r;
			bus_access(1'b1, blk_addr(blk_idx[i]), r, 1'b0, 1'b0, '0, 1'b0);
		end
		for (i = 0; i < 64; i++)
			bus_access(1'b0, blk_addr(blk_idx[i]), '0, 1'b0, 1'b1, shadow[blk_idx[i]], 1'b0);
		report_test("block RAM");

		bus_access(1'b0, io_addr(IO_ERR_ADDR), '0, 1'b0, 1'b1, '0, 1'b0);
		r = next_rand();
		sw = r[SW_W-1:0];
		r = next_rand();
		bus_access(1'b1, io_addr(IO_LEDS), r, 1'b0, 1'b0, '0, 1'b0);
		compare_word({28'd0, led}, {28'd0, r[LED_W-1:0]}, "LED output");
		bus_access(1'b0, io_addr(IO_LEDS), '0, 1'b0, 1'b1, {28'd0, r[LED_W-1:0]}, 1'b0);
		bus_access(1'b0, io_addr(IO_SWITCHES), '0, 1'b0, 1'b1, {28'd0, sw}, 1'b0);
		// Unused indices ignore writes
		for (i = 3; i < 8; i++)
		begin
			bus_access(1'b1, io_addr(3'(i)), next_rand(), 1'b0, 1'b0, '0, 1'b0);
			bus_access(1'b0, io_addr(3'(i)), '0, 1'b0, 1'b1, '0, 1'b0);
		end
		report_test("I/O registers");

		for (i = 0; i < 24; i++)
		begin
			r = next_rand();
			a = {6'b000001, r[EXT_AW-1:0]};
			r = next_rand();
			if (r[0])
				bus_access(1'b1, a, r, 1'b0, 1'b0, '0, 1'b0);
			else
				bus_access(1'b0, a, '0, 1'b0, 1'b1, ram_word(a[EXT_AW-1:0]), 1'b0);
		end
		report_test("external RAM");

		// Near misses of the block RAM and I/O windows, plus plain random
		for (i = 0; i < 16; i++)
		begin
			do
			begin
				r = next_rand();
				case (r[1:0])
				2'd0: a = next_rand();
				2'd1: a = blk_addr('0) | (next_rand() & 32'h03FF_7FFF);
				default: a = io_addr('0) | (next_rand() & 32'h03FF_7EFF);
				endcase
			end
			while (ref_region(a) != REGION_NONE);
			bus_access(r[2], a, next_rand(), 1'b1, 1'b0, '0, 1'b0);
			bus_access(1'b0, io_addr(IO_ERR_ADDR), '0, 1'b0, 1'b1, a, 1'b0);
		end
		report_test("bad addresses");

		err_inject = 1'b1;
		r = next_rand();
		a = {6'b000001, r[EXT_AW-1:0]};
		bus_access(1'b0, a, '0, 1'b1, 1'b0, '0, 1'b0);
		bus_access(1'b1, a, r, 1'b1, 1'b0, '0, 1'b0);
		err_inject = 1'b0;
		// Stray RAM ack collides with the block RAM ack
		bus_access(1'b0, blk_addr(r[BLK_AW-1:0]), '0, 1'b1, 1'b0, '0, 1'b1);
		bus_access(1'b0, io_addr(IO_ERR_ADDR), '0, 1'b0, 1'b1, blk_addr(r[BLK_AW-1:0]), 1'b0);
		report_test("slave errors");

		$display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- vlog.f
logic/bus_pkg.sv
logic/bus_decode.sv
logic/bus_ctrl.sv
logic/resp_mux.sv
logic/blk_ram.sv
logic/io_regs.sv
logic/bus_fabric.sv
test/tb_bus_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bus fabric testbench, pass only if the log says so
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_bus_fabric -o sim_bus_fabric \
	&& ./obj_dir/sim_bus_fabric | tee sim.log \
	&& grep -q "Verification passed" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
